// File: conv_tests.txt
// per test: number, relu flag, gap flag; 25 weights row-major; bias;
// then 64 pixels of the 8x8 plane and the 16 expected outputs, raster order.
0004
// identity kernel, back-to-back strobes.
0001 0000 0000
0000 0000 0000 0000 0000
0000 0000 0000 0000 0000
0000 0000 0100 0000 0000
0000 0000 0000 0000 0000
0000 0000 0000 0000 0000
0000
0000 0001 0002 0003 0004 0005 0006 0007
0010 0011 0012 0013 0014 0015 0016 0017
0020 0021 0022 0023 0024 0025 0026 0027
0030 0031 0032 0033 0034 0035 0036 0037
0040 0041 0042 0043 0044 0045 0046 0047
0050 0051 0052 0053 0054 0055 0056 0057
0060 0061 0062 0063 0064 0065 0066 0067
0070 0071 0072 0073 0074 0075 0076 0077
0022 0023 0024 0025 0032 0033 0034 0035 0042 0043 0044 0045 0052 0053 0054 0055
// all weights 1.0 and bias 1.0; negative pixels lose one lsb each.
0002 0000 0001
0100 0100 0100 0100 0100
0100 0100 0100 0100 0100
0100 0100 0100 0100 0100
0100 0100 0100 0100 0100
0100 0100 0100 0100 0100
0100
FFC0 FFC1 FFC2 FFC3 FFC4 FFC5 FFC6 FFC7
FFD0 FFD1 FFD2 FFD3 FFD4 FFD5 FFD6 FFD7
FFE0 FFE1 FFE2 FFE3 FFE4 FFE5 FFE6 FFE7
FFF0 FFF1 FFF2 FFF3 FFF4 FFF5 FFF6 FFF7
0000 0001 0002 0003 0004 0005 0006 0007
0010 0011 0012 0013 0014 0015 0016 0017
0020 0021 0022 0023 0024 0025 0026 0027
0030 0031 0032 0033 0034 0035 0036 0037
FDFE FE17 FE30 FE49 FF93 FFAC FFC5 FFDE 0128 0141 015A 0173 02BD 02D6 02EF 0308
// all weights -1.0, bias -0.5 and relu on, so the lower rows clamp to zero.
0003 0001 0001
FF00 FF00 FF00 FF00 FF00
FF00 FF00 FF00 FF00 FF00
FF00 FF00 FF00 FF00 FF00
FF00 FF00 FF00 FF00 FF00
FF00 FF00 FF00 FF00 FF00
FF80
FFC0 FFC1 FFC2 FFC3 FFC4 FFC5 FFC6 FFC7
FFD0 FFD1 FFD2 FFD3 FFD4 FFD5 FFD6 FFD7
FFE0 FFE1 FFE2 FFE3 FFE4 FFE5 FFE6 FFE7
FFF0 FFF1 FFF2 FFF3 FFF4 FFF5 FFF6 FFF7
0000 0001 0002 0003 0004 0005 0006 0007
0010 0011 0012 0013 0014 0015 0016 0017
0020 0021 0022 0023 0024 0025 0026 0027
0030 0031 0032 0033 0034 0035 0036 0037
026A 0250 0237 021E 00D5 00BB 00A2 0089 0000 0000 0000 0000 0000 0000 0000 0000
// corner weights 2.0 and 0.5 with bias 1/16.
0004 0000 0001
0200 0000 0000 0000 0000
0000 0000 0000 0000 0000
0000 0000 0000 0000 0000
0000 0000 0000 0000 0000
0000 0000 0000 0000 0080
0010
0000 0001 0002 0003 0004 0005 0006 0007
0010 0011 0012 0013 0014 0015 0016 0017
0020 0021 0022 0023 0024 0025 0026 0027
0030 0031 0032 0033 0034 0035 0036 0037
0040 0041 0042 0043 0044 0045 0046 0047
0050 0051 0052 0053 0054 0055 0056 0057
0060 0061 0062 0063 0064 0065 0066 0067
0070 0071 0072 0073 0074 0075 0076 0077
0032 0034 0037 0039 005A 005C 005F 0061 0082 0084 0087 0089 00AA 00AC 00AF 00B1

// File: verilog.f
+incdir+.
renkon_fixed_pkg.sv
renkon_ctrl_pkg.sv
conv_tree25.sv
conv_window5.sv
weight_store.sv
conv_ctrl.sv
bias_relu.sv
conv_unit.sv
tb_conv_unit.sv

// File: Bender.yml
package:
  name: renkon_conv

sources:
  - include_dirs:
      - .
    files:
      - renkon_fixed_pkg.sv
      - renkon_ctrl_pkg.sv
      - conv_tree25.sv
      - conv_window5.sv
      - weight_store.sv
      - conv_ctrl.sv
      - bias_relu.sv
      - conv_unit.sv
      - target: test
        files:
          - tb_conv_unit.sv

// File: tb_conv_unit.sv
`timescale 1ns/10ps
`include "renkon_consts.svh"

module tb_conv_unit
  import renkon_fixed_pkg::*;
  ();

  localparam int  NTAP       = `FSIZE * `FSIZE;
  localparam int  NPIX       = `IMG_WIDTH * `IMG_WIDTH;
  localparam int  NOUT       = (`IMG_WIDTH - `FSIZE + 1) * (`IMG_WIDTH - `FSIZE + 1);
  localparam int  HDR        = 3;
  localparam int  TEST_WORDS = HDR + NTAP + 1 + NPIX + NOUT;
  localparam int  MEM_DEPTH  = 1024;
  localparam int  VALID_LAT  = 7;
  localparam time PERIOD     = 8;

  logic  clk;
  logic  xrst;
  logic  weight_load;
  word_t weight_in;
  logic  frame_start;
  logic  pixel_en;
  word_t pixel_in;
  logic  relu_en;
  logic  out_valid;
  word_t out_data;

  logic [15:0] tests [MEM_DEPTH];
  word_t       exp_q [$];
  int          due_q [$];
  int          cyc        = 0;
  int          ntests     = 0;
  int          n_expected = 0;
  int          n_seen     = 0;
  logic [31:0] rng        = 32'he89a_5606;

  conv_unit u_dut
    ( .clk         (clk)
    , .xrst        (xrst)
    , .weight_load (weight_load)
    , .weight_in   (weight_in)
    , .frame_start (frame_start)
    , .pixel_en    (pixel_en)
    , .pixel_in    (pixel_in)
    , .relu_en     (relu_en)
    , .out_valid   (out_valid)
    , .out_data    (out_data)
    );

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2) clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1; // counts rising edges.
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERROR at %0t: %s is %0h, expected %0h.",
                                  $time, what, got, exp));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // runs one plane with frame_start, 26 load words, then the pixels in raster order.
  task automatic run_test(input int t);
    int base;
    int row;
    int col;
    base = 1 + t * TEST_WORDS;
    check_value("test number in conv_tests.txt", tests[base], t + 1);
    relu_en     = tests[base+1][0];
    frame_start = 1'b1;
    next_cycle();
    frame_start = 1'b0;
    for (int i = 0; i <= NTAP; i++) begin
      weight_load = 1'b1;
      weight_in   = tests[base+HDR+i];
      next_cycle();
    end
    weight_load = 1'b0;
    for (int i = 0; i < NOUT; i++) begin
      exp_q.push_back(tests[base+HDR+NTAP+1+NPIX+i]);
    end
    n_expected += NOUT;
    for (int i = 0; i < NPIX; i++) begin
      row = i / `IMG_WIDTH;
      col = i % `IMG_WIDTH;
      if (tests[base+2] != 16'h0) begin
        rng = xorshift32(rng);
        repeat (rng[1:0]) next_cycle(); // up to three idle cycles before the strobe.
      end
      pixel_en = 1'b1;
      pixel_in = tests[base+HDR+NTAP+1+i];
      if (row >= `FSIZE - 1 && col >= `FSIZE - 1) begin
        due_q.push_back(cyc + VALID_LAT); // this strobe completes a window.
      end
      next_cycle();
      pixel_en = 1'b0;
    end
    wait (n_seen == n_expected);
    next_cycle();
  endtask

  // outputs are sampled half a cycle after the edge that launched them.
  always @(negedge clk) begin
    if (xrst === 1'b1 && out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        stop_with_failure($sformatf("ERROR at %0t: out_valid pulsed with no output expected.",
                                    $time));
      end else begin
        check_value($sformatf("cycle of output %0d", n_seen), cyc, due_q.pop_front());
        check_value($sformatf("value of output %0d", n_seen), out_data, exp_q.pop_front());
        n_seen++;
      end
    end
  end

  initial begin
    wait (ntests > 0);
    #(PERIOD * (ntests * (NTAP + 1 + NPIX * 4 + 20) + 40));
    stop_with_failure($sformatf("Timeout: the outputs never arrived, %0d of %0d seen.",
                                n_seen, n_expected));
  end

  initial begin
    $timeformat(-9, 0, " ns", 0);
    xrst        = 1'b0;
    weight_load = 1'b0;
    weight_in   = '0;
    frame_start = 1'b0;
    pixel_en    = 1'b0;
    pixel_in    = '0;
    relu_en     = 1'b0;
    $readmemh("conv_tests.txt", tests);
    ntests = tests[0];
    if (ntests < 1 || 1 + ntests * TEST_WORDS > MEM_DEPTH) begin
      stop_with_failure("The file conv_tests.txt could not be read or has a bad test count.");
    end
    repeat (2) next_cycle();
    xrst = 1'b1;
    repeat (10) begin
      @(negedge clk);
      check_value("out_valid while idle", out_valid, 1'b0);
      check_value("out_data while idle", out_data, '0);
    end
    next_cycle();
    for (int t = 0; t < ntests; t++) begin
      run_test(t);
    end
    repeat (10) next_cycle(); // no stray strobes may follow the last plane.
    if (n_seen == n_expected && exp_q.size() == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stop_with_failure("The number of outputs does not match the test file.");
    end
  end

endmodule

// File: conv_unit.sv
`timescale 1ns/10ps
`include "renkon_consts.svh"

module conv_unit
  import renkon_fixed_pkg::*;
  ( input  logic  clk
  , input  logic  xrst
  , input  logic  weight_load
  , input  word_t weight_in
  , input  logic  frame_start
  , input  logic  pixel_en
  , input  word_t pixel_in
  , input  logic  relu_en
  , output logic  out_valid
  , output word_t out_data
  );

  word_t window [`FSIZE*`FSIZE];
  word_t weight [`FSIZE*`FSIZE];
  word_t bias;
  word_t fmap;

  conv_window5 u_window
    ( .clk         (clk)
    , .xrst        (xrst)
    , .frame_start (frame_start)
    , .pixel_en    (pixel_en)
    , .pixel_in    (pixel_in)
    , .window      (window)
    );

  weight_store u_weights
    ( .clk         (clk)
    , .xrst        (xrst)
    , .frame_start (frame_start)
    , .weight_load (weight_load)
    , .weight_in   (weight_in)
    , .weight      (weight)
    , .bias        (bias)
    );

  conv_tree25 u_tree
    ( .clk    (clk)
    , .xrst   (xrst)
    , .pixel  (window)
    , .weight (weight)
    , .fmap   (fmap)
    );

  conv_ctrl u_ctrl
    ( .clk         (clk)
    , .xrst        (xrst)
    , .frame_start (frame_start)
    , .pixel_en    (pixel_en)
    , .out_valid   (out_valid)
    );

  bias_relu u_bias_relu
    ( .clk      (clk)
    , .xrst     (xrst)
    , .fmap     (fmap)
    , .bias     (bias)
    , .relu_en  (relu_en)
    , .out_data (out_data)
    );

endmodule

// File: bias_relu.sv
`timescale 1ns/10ps
`include "renkon_consts.svh"

module bias_relu
  import renkon_fixed_pkg::*;
  ( input  logic  clk
  , input  logic  xrst
  , input  word_t fmap
  , input  word_t bias
  , input  logic  relu_en
  , output word_t out_data
  );

  word_t sum;

  assign sum = fmap + bias; // wraps like the tree sums.

  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_data <= '0;
    end else if (relu_en && sum[`DWIDTH-1]) begin
      out_data <= '0;
    end else begin
      out_data <= sum;
    end
  end

endmodule

// File: conv_ctrl.sv
`timescale 1ns/10ps
`include "renkon_consts.svh"

module conv_ctrl
  import renkon_ctrl_pkg::*;
  ( input  logic clk
  , input  logic xrst
  , input  logic frame_start
  , input  logic pixel_en
  , output logic out_valid
  );

  ctrl_state_t          state;
  pos_t                 row;
  pos_t                 col;
  logic                 take;
  logic                 win_valid;
  logic [`TREE_LAT:0]   valid_sr;

  assign take      = pixel_en && !frame_start && state == run;
  assign out_valid = valid_sr[`TREE_LAT];

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= idle;
    end else if (frame_start) begin
      state <= run;
    end
  end

  // row and col point at the pixel being taken.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      row <= '0;
      col <= '0;
    end else if (frame_start) begin
      row <= '0;
      col <= '0;
    end else if (take) begin
      if (col == pos_t'(`IMG_WIDTH-1)) begin
        col <= '0;
        row <= row + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  // flag lines up with the window register, then rides along the tree and bias stage.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      win_valid <= 1'b0;
      valid_sr  <= '0;
    end else begin
      win_valid <= take && row >= pos_t'(`FSIZE-1) && col >= pos_t'(`FSIZE-1);
      valid_sr  <= {valid_sr[`TREE_LAT-1:0], win_valid};
    end
  end

endmodule

// File: weight_store.sv
`timescale 1ns/10ps
`include "renkon_consts.svh"

module weight_store
  import renkon_fixed_pkg::*;
  ( input  logic  clk
  , input  logic  xrst
  , input  logic  frame_start
  , input  logic  weight_load
  , input  word_t weight_in
  , output word_t weight [`FSIZE*`FSIZE]
  , output word_t bias
  );

  localparam int NTAP = `FSIZE * `FSIZE;

  logic [4:0] load_idx;
  logic       take;

  assign take = weight_load && !frame_start && load_idx != 5'(NTAP + 1);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      load_idx <= '0;
    end else if (frame_start) begin
      load_idx <= '0;
    end else if (take) begin
      load_idx <= load_idx + 1'b1; // parks at 26 once the bias is in.
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      weight <= '{default: '0};
      bias   <= '0;
    end else if (take) begin
      for (int i = 0; i < NTAP; i++) begin
        if (load_idx == 5'(i)) begin
          weight[i] <= weight_in;
        end
      end
      if (load_idx == 5'(NTAP)) begin
        bias <= weight_in;
      end
    end
  end

endmodule

// File: conv_window5.sv
`timescale 1ns/10ps
`include "renkon_consts.svh"

module conv_window5
  import renkon_fixed_pkg::*;
  ( input  logic  clk
  , input  logic  xrst
  , input  logic  frame_start
  , input  logic  pixel_en
  , input  word_t pixel_in
  , output word_t window [`FSIZE*`FSIZE]
  );

  localparam int AW = $clog2(`IMG_WIDTH);

  word_t          line_buf [`FSIZE-1][`IMG_WIDTH];
  word_t          tap      [`FSIZE-1];
  word_t          newest   [`FSIZE];
  word_t          win      [`FSIZE][`FSIZE];
  logic [AW-1:0]  wr_idx;
  logic           shift;

  assign shift = pixel_en && !frame_start;

  // buffer k returns the pixel from k+1 lines above the incoming one.
  for (genvar k = 0; k < `FSIZE-1; k++) begin : g_tap
    assign tap[k]                = line_buf[k][wr_idx];
    assign newest[`FSIZE-2-k]    = tap[k];
  end
  assign newest[`FSIZE-1] = pixel_in; // bottom row takes the live pixel.

  // window index is row*5+col with row 0 the oldest line and col 4 the newest pixel.
  for (genvar r = 0; r < `FSIZE; r++) begin : g_row
    for (genvar c = 0; c < `FSIZE; c++) begin : g_col
      assign window[r*`FSIZE+c] = win[r][c];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wr_idx <= '0;
    end else if (frame_start) begin
      wr_idx <= '0;
    end else if (shift) begin
      wr_idx <= (wr_idx == AW'(`IMG_WIDTH-1)) ? '0 : wr_idx + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (shift) begin
      line_buf[0][wr_idx] <= pixel_in;
      for (int k = 1; k < `FSIZE-1; k++) begin
        line_buf[k][wr_idx] <= tap[k-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      win <= '{default: '0};
    end else if (shift) begin
      for (int r = 0; r < `FSIZE; r++) begin
        for (int c = 0; c < `FSIZE-1; c++) begin
          win[r][c] <= win[r][c+1];
        end
        win[r][`FSIZE-1] <= newest[r];
      end
    end
  end

endmodule

// File: conv_tree25.sv
`timescale 1ns/10ps
`include "renkon_consts.svh"

module conv_tree25
  import renkon_fixed_pkg::*;
  ( input  logic  clk
  , input  logic  xrst
  , input  word_t pixel  [`FSIZE*`FSIZE]
  , input  word_t weight [`FSIZE*`FSIZE]
  , output word_t fmap
  );

  localparam int NTAP = `FSIZE * `FSIZE;

  word_t r_pixel     [NTAP];
  word_t r_weight    [NTAP];
  prod_t r_pro       [NTAP];
  word_t r_pro_short [NTAP];
  word_t r_pro_short24_d1;

  word_t sum0   [12];
  word_t sum1   [6];
  word_t sum2   [3];
  word_t r_sum2 [3];
  word_t sum3_0;
  word_t sum3_1;
  word_t r_fmap;

  // terms 0 to 23 pair up over three levels; term 24 waits one clock beside them.
  for (genvar i = 0; i < 12; i++) begin : g_lvl0
    assign sum0[i] = r_pro_short[2*i] + r_pro_short[2*i+1];
  end

  for (genvar i = 0; i < 6; i++) begin : g_lvl1
    assign sum1[i] = sum0[2*i] + sum0[2*i+1];
  end

  for (genvar i = 0; i < 3; i++) begin : g_lvl2
    assign sum2[i] = sum1[2*i] + sum1[2*i+1];
  end

  assign sum3_0 = r_sum2[0] + r_sum2[1];
  assign sum3_1 = r_sum2[2] + r_pro_short24_d1;

  assign fmap = r_fmap;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_pixel  <= '{default: '0};
      r_weight <= '{default: '0};
    end else begin
      r_pixel  <= pixel;
      r_weight <= weight;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_pro <= '{default: '0};
    end else begin
      for (int i = 0; i < NTAP; i++) begin
        r_pro[i] <= r_pixel[i] * r_weight[i]; // operands widen to the product width.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_pro_short <= '{default: '0};
    end else begin
      for (int i = 0; i < NTAP; i++) begin
        r_pro_short[i] <= round_prod(r_pro[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_sum2           <= '{default: '0};
      r_pro_short24_d1 <= '0;
    end else begin
      r_sum2           <= sum2;
      r_pro_short24_d1 <= r_pro_short[NTAP-1];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_fmap <= '0;
    end else begin
      r_fmap <= sum3_0 + sum3_1; // sums wrap at word width.
    end
  end

  // Shift right by the fraction width, keeping bit 22 as the sign.
  // a negative product with an all-zero low byte loses one more lsb.
  function automatic word_t round_prod(input prod_t data);
    logic               sign;
    logic [`DWIDTH-2:0] field;
    sign  = data[2*`DWIDTH-`DWIDTH/2-2];
    field = data[2*`DWIDTH-`DWIDTH/2-2:`DWIDTH/2];
    if (sign && data[`DWIDTH/2-1:0] == '0) begin
      field = field - 1'b1;
    end
    return $signed({sign, field});
  endfunction

endmodule

// File: renkon_ctrl_pkg.sv
package renkon_ctrl_pkg;

  // the controller waits in idle until the first frame_start.
  typedef enum logic {
    idle,
    run
  } ctrl_state_t;

  typedef logic [15:0] pos_t;

endpackage

// File: renkon_fixed_pkg.sv
`include "renkon_consts.svh"

package renkon_fixed_pkg;

  // signed fixed point with DWIDTH/2 fraction bits.
  typedef logic signed [`DWIDTH-1:0] word_t;

  // full precision product of two words.
  typedef logic signed [2*`DWIDTH-1:0] prod_t;

endpackage

// File: renkon_consts.svh
`ifndef RENKON_CONSTS_SVH
`define RENKON_CONSTS_SVH

// word width; the lower half of each word is the fraction.
`define DWIDTH 16

// the filter is five pixels on a side and the tree is built for that size only.
`define FSIZE 5

// plane width in pixels; any value of 5 or more works.
`define IMG_WIDTH 8

// clocks from window register to tree output register.
`define TREE_LAT 5

`endif
